/* source/dino_pkg.sv */
package dino_pkg;

	// Screen coordinate and score widths
	localparam int X_W = 9;
	localparam int Y_W = 8;
	localparam int SCORE_W = 16;

	// UART timing
	localparam int OS_DIV = 4;		// Clocks per oversampling tick, small for fast sims
	localparam int BIT_OS = 16;		// Oversampling ticks per bit
	localparam int OS_DIV_W = $clog2(OS_DIV);
	localparam int BIT_CNT_W = $clog2(BIT_OS);

	// Game timing
	localparam int TICK_DIV = 8;		// Clocks per game tick
	localparam int TICK_W = $clog2(TICK_DIV);
	localparam int PHYS_DIV = 2;		// Game ticks per runner physics step
	localparam int PHYS_W = $clog2(PHYS_DIV);
	localparam int DUCK_TICKS = 40;
	localparam int DUCK_W = $clog2(DUCK_TICKS + 1);

	// Runner motion
	localparam logic [Y_W-1:0] GROUND_Y = 8'd109;
	localparam logic [X_W-1:0] RUNNER_X = 9'd52;
	localparam logic signed [Y_W:0] JUMP_FORCE = -9'sd10;
	localparam logic signed [Y_W:0] GRAVITY = 9'sd1;

	// Hitboxes, the runner box sits inside a 32x32 sprite
	localparam logic [X_W-1:0] RUN_HB_W = 9'd20;
	localparam logic [Y_W-1:0] RUN_HB_H = 8'd30;
	localparam logic [Y_W-1:0] DUCK_HB_H = 8'd15;
	localparam logic [X_W-1:0] RUN_HB_X_OFS = 9'd6;
	localparam logic [Y_W-1:0] RUN_HB_Y_OFS = 8'd2;
	localparam int OBS_HB = 16;
	// Obstacle stands on the same ground line as the runner's feet
	localparam logic [Y_W-1:0] OBS_Y = GROUND_Y + RUN_HB_Y_OFS + RUN_HB_H - Y_W'(OBS_HB);

	// Obstacle respawn
	localparam logic [X_W-1:0] OBS_START = 9'd304;	// 320 minus sprite width
	localparam int OBS_RAND_MAX = 100;
	localparam int RAND_W = $clog2(OBS_RAND_MAX);
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {CMD_NONE, CMD_JUMP, CMD_DUCK, CMD_IDLE} cmd_t;
	typedef enum logic {RUNNING, AIRBORNE} air_state_t;

endpackage

/* source/uart_receiver.sv */
`timescale 1ns/1ps

module uart_receiver (
	input logic Clock,
	input logic rst_n,
	input logic rx,
	output logic byte_valid,
	output logic [7:0] rx_byte
);
	import dino_pkg::*;

	logic rx_m, rx_s;
	logic [OS_DIV_W-1:0] os_cnt;
	logic os_tick;
	rx_state_t state;
	logic [BIT_CNT_W-1:0] os_left;		// Ticks until the next sample point
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic sample;

	// Line idles high, so the synchronizer resets to 1
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_m <= 1'b1;
			rx_s <= 1'b1;
		end else begin
			rx_m <= rx;
			rx_s <= rx_m;
		end
	end

	assign os_tick = (os_cnt == OS_DIV_W'(OS_DIV - 1));

	always_ff @(posedge Clock) begin
		if (!rst_n)
			os_cnt <= '0;
		else if (os_tick)
			os_cnt <= '0;
		else
			os_cnt <= os_cnt + 1'b1;
	end

	assign sample = os_tick && (os_left == '0);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			os_left <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (os_tick && !sample)
				os_left <= os_left - 1'b1;
			case (state)
				RX_IDLE: if (os_tick && !rx_s) begin
					state <= RX_START;
					os_left <= BIT_CNT_W'(BIT_OS / 2 - 1);	// Aim at the middle of the start bit
				end
				RX_START: if (sample) begin
					if (!rx_s) begin
						state <= RX_DATA;
						os_left <= BIT_CNT_W'(BIT_OS - 1);
						bit_idx <= '0;
					end else begin
						state <= RX_IDLE;	// Glitch, not a real start bit
					end
				end
				RX_DATA: if (sample) begin
					os_left <= BIT_CNT_W'(BIT_OS - 1);
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (sample) begin
					byte_valid <= rx_s;		// Framing error drops the byte
					state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge Clock) begin
		if (state == RX_DATA && sample)
			shift <= {rx_s, shift[7:1]};
		if (state == RX_STOP && sample && rx_s)
			rx_byte <= shift;
	end

	assert property (@(posedge Clock) disable iff (!rst_n) byte_valid |=> !byte_valid)
		else $error("byte_valid held for more than one cycle");

endmodule

/* source/command_decoder.sv */
`timescale 1ns/1ps

module command_decoder (
	input logic Clock,
	input logic rst_n,
	input logic byte_valid,
	input logic [7:0] rx_byte,
	input logic jump_key,
	input logic duck_key,
	output dino_pkg::cmd_t cmd,
	output logic jump_cmd,
	output logic duck_cmd,
	output logic idle_cmd
);
	import dino_pkg::*;

	// Bit 0 is the jump key, bit 1 the duck key
	logic [1:0] key_m, key_s, key_prev, key_edge;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			cmd <= CMD_NONE;
		end else if (byte_valid) begin
			case (rx_byte)
				"J": cmd <= CMD_JUMP;
				"D": cmd <= CMD_DUCK;
				"I": cmd <= CMD_IDLE;
				default: cmd <= CMD_NONE;	// Anything else is noise
			endcase
		end else begin
			cmd <= CMD_NONE;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_m <= '0;
			key_s <= '0;
			key_prev <= '0;
			key_edge <= '0;
		end else begin
			key_m <= {duck_key, jump_key};
			key_s <= key_m;
			key_prev <= key_s;
			key_edge <= key_s & ~key_prev;	// One pulse per press
		end
	end

	assign jump_cmd = (cmd == CMD_JUMP) || key_edge[0];
	assign duck_cmd = (cmd == CMD_DUCK) || key_edge[1];
	assign idle_cmd = (cmd == CMD_IDLE);

endmodule

/* source/runner_physics.sv */
`timescale 1ns/1ps

module runner_physics (
	input logic Clock,
	input logic rst_n,
	input logic restart,
	input logic game_over,
	input logic jump_cmd,
	input logic duck_cmd,
	output logic game_tick,
	output logic [dino_pkg::Y_W-1:0] runner_y,
	output logic ducking
);
	import dino_pkg::*;

	logic [TICK_W-1:0] tick_cnt;
	air_state_t air;
	logic signed [Y_W:0] vel;		// Negative is upward
	logic [PHYS_W-1:0] phys_cnt;
	logic phys_step;
	logic signed [Y_W+1:0] next_y;
	logic [DUCK_W-1:0] duck_cnt;

	assign game_tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

	always_ff @(posedge Clock) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (game_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign phys_step = game_tick && (phys_cnt == PHYS_W'(PHYS_DIV - 1));
	assign next_y = $signed({2'b00, runner_y}) + vel;

	always_ff @(posedge Clock) begin
		if (!rst_n || restart) begin
			air <= RUNNING;
			vel <= '0;
			runner_y <= GROUND_Y;
			phys_cnt <= '0;
		end else if (!game_over) begin		// Frozen after a crash
			if (jump_cmd && air == RUNNING && !ducking) begin
				air <= AIRBORNE;
				vel <= JUMP_FORCE;
				phys_cnt <= '0;			// Every jump starts on the same phase
			end else if (game_tick) begin
				phys_cnt <= phys_step ? '0 : phys_cnt + 1'b1;
				if (phys_step && air == AIRBORNE) begin
					vel <= vel + GRAVITY;
					// Landing is predicted so the runner never sinks below ground
					if (next_y >= $signed({2'b00, GROUND_Y})) begin
						runner_y <= GROUND_Y;
						vel <= '0;
						air <= RUNNING;
					end else begin
						runner_y <= next_y[Y_W-1:0];
					end
				end
			end
		end
	end

	assign ducking = (duck_cnt != '0);

	always_ff @(posedge Clock) begin
		if (!rst_n || restart)
			duck_cnt <= '0;
		else if (!game_over) begin
			if (duck_cmd && air == RUNNING && !ducking)
				duck_cnt <= DUCK_W'(DUCK_TICKS);
			else if (game_tick && ducking)
				duck_cnt <= duck_cnt - 1'b1;
		end
	end

	assert property (@(posedge Clock) disable iff (!rst_n) runner_y <= GROUND_Y)
		else $error("runner below ground");

endmodule

/* source/obstacle_track.sv */
`timescale 1ns/1ps

module obstacle_track (
	input logic Clock,
	input logic rst_n,
	input logic restart,
	input logic game_over,
	input logic game_tick,
	input logic respawn,
	output logic [dino_pkg::X_W-1:0] obstacle_x
);
	import dino_pkg::*;

	logic [15:0] lfsr;
	logic feedback;
	logic [RAND_W-1:0] rand_ofs;

	// Free running, restart does not reseed it
	assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], feedback};
	end

	assign rand_ofs = RAND_W'(lfsr % OBS_RAND_MAX);

	always_ff @(posedge Clock) begin
		if (!rst_n || restart) begin
			obstacle_x <= OBS_START;
		end else if (respawn) begin
			obstacle_x <= OBS_START + X_W'(rand_ofs);	// Off screen by a random gap
		end else if (game_tick && !game_over) begin
			if (obstacle_x <= X_W'(1))
				obstacle_x <= OBS_START;	// Left edge reached
			else
				obstacle_x <= obstacle_x - 1'b1;
		end
	end

endmodule

/* source/score_keeper.sv */
`timescale 1ns/1ps

module score_keeper (
	input logic Clock,
	input logic rst_n,
	input logic restart,
	input logic [dino_pkg::Y_W-1:0] runner_y,
	input logic ducking,
	input logic [dino_pkg::X_W-1:0] obstacle_x,
	output logic game_over,
	output logic respawn,
	output logic [dino_pkg::SCORE_W-1:0] score,
	output logic [dino_pkg::SCORE_W-1:0] high_score
);
	import dino_pkg::*;

	// One extra bit so box edges never wrap
	logic [X_W:0] run_left, run_right, obs_left, obs_right;
	logic [Y_W:0] run_top, run_bot, obs_top, obs_bot;
	logic [Y_W-1:0] hb_h;
	logic collision;
	logic [X_W-1:0] prev_x;
	logic score_given;
	logic passed;
	logic game_over_d;

	assign hb_h = ducking ? DUCK_HB_H : RUN_HB_H;

	assign run_left = {1'b0, RUNNER_X + RUN_HB_X_OFS};
	assign run_right = run_left + {1'b0, RUN_HB_W};
	assign obs_left = {1'b0, obstacle_x};
	assign obs_right = obs_left + {1'b0, X_W'(OBS_HB)};
	assign run_top = {1'b0, runner_y} + {1'b0, RUN_HB_Y_OFS};
	assign run_bot = run_top + {1'b0, hb_h};
	assign obs_top = {1'b0, OBS_Y};
	assign obs_bot = obs_top + {1'b0, Y_W'(OBS_HB)};

	assign collision = (run_right >= obs_left) && (run_left <= obs_right) &&
		(run_bot >= obs_top) && (run_top <= obs_bot);

	// Obstacle moved from right of the runner's column onto it without a hit
	assign passed = (prev_x > RUNNER_X) && (obstacle_x <= RUNNER_X) &&
		!score_given && !collision;

	always_ff @(posedge Clock) begin
		if (!rst_n || restart) begin
			game_over <= 1'b0;
			prev_x <= OBS_START;
			score_given <= 1'b0;
			respawn <= 1'b0;
			score <= '0;
		end else begin
			prev_x <= obstacle_x;
			respawn <= passed;
			if (collision)
				game_over <= 1'b1;
			if (passed) begin
				score <= score + 1'b1;
				score_given <= 1'b1;
			end else if (obstacle_x > prev_x) begin
				score_given <= 1'b0;	// Reload or wrap brings a new obstacle
			end
		end
	end

	// High score survives restart
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over_d <= 1'b0;
			high_score <= '0;
		end else begin
			game_over_d <= game_over;
			if (game_over && !game_over_d && score > high_score)
				high_score <= score;
		end
	end

	assert property (@(posedge Clock) disable iff (!rst_n)
		(game_over && !restart) |=> $stable(score))
		else $error("score changed after game over");

endmodule

/* source/score_display.sv */
`timescale 1ns/1ps

module score_display (
	input logic [dino_pkg::SCORE_W-1:0] score,
	input logic [dino_pkg::SCORE_W-1:0] high_score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);
	logic [3:0] s_ones, s_tens, s_hund;
	logic [3:0] h_ones, h_tens, h_hund;

	// Active low, segment g in bit 6
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0: seg7 = 7'b1000000;
			4'd1: seg7 = 7'b1111001;
			4'd2: seg7 = 7'b0100100;
			4'd3: seg7 = 7'b0110000;
			4'd4: seg7 = 7'b0011001;
			4'd5: seg7 = 7'b0010010;
			4'd6: seg7 = 7'b0000010;
			4'd7: seg7 = 7'b1111000;
			4'd8: seg7 = 7'b0000000;
			4'd9: seg7 = 7'b0010000;
			default: seg7 = 7'b1111111;	// Blank
		endcase
	endfunction

	assign s_ones = 4'(score % 10);
	assign s_tens = 4'((score / 10) % 10);
	assign s_hund = 4'((score / 100) % 10);
	assign h_ones = 4'(high_score % 10);
	assign h_tens = 4'((high_score / 10) % 10);
	assign h_hund = 4'((high_score / 100) % 10);

	// Current score on the right three digits, best on the left three
	assign hex0 = seg7(s_ones);
	assign hex1 = seg7(s_tens);
	assign hex2 = seg7(s_hund);
	assign hex3 = seg7(h_ones);
	assign hex4 = seg7(h_tens);
	assign hex5 = seg7(h_hund);

endmodule

/* source/dino_top.sv */
`timescale 1ns/1ps

module dino_top (
	input logic Clock,
	input logic rst_n,
	input logic uart_rx,
	input logic jump_key,
	input logic duck_key,
	input logic restart,
	output logic jump_cmd,
	output logic duck_cmd,
	output logic idle_cmd,
	output logic game_over,
	output logic [dino_pkg::Y_W-1:0] runner_y,
	output logic [dino_pkg::X_W-1:0] obstacle_x,
	output logic [dino_pkg::SCORE_W-1:0] score,
	output logic [dino_pkg::SCORE_W-1:0] high_score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);
	logic byte_valid;
	logic [7:0] rx_byte;
	logic game_tick;
	logic ducking;
	logic respawn;

	// Decode
	uart_receiver i_uart (.Clock(Clock), .rst_n(rst_n), .rx(uart_rx),
		.byte_valid(byte_valid), .rx_byte(rx_byte));

	command_decoder i_decoder (.Clock(Clock), .rst_n(rst_n), .byte_valid(byte_valid),
		.rx_byte(rx_byte), .jump_key(jump_key), .duck_key(duck_key), .cmd(),
		.jump_cmd(jump_cmd), .duck_cmd(duck_cmd), .idle_cmd(idle_cmd));

	// Execute
	runner_physics i_runner (.Clock(Clock), .rst_n(rst_n), .restart(restart),
		.game_over(game_over), .jump_cmd(jump_cmd), .duck_cmd(duck_cmd),
		.game_tick(game_tick), .runner_y(runner_y), .ducking(ducking));

	obstacle_track i_obstacle (.Clock(Clock), .rst_n(rst_n), .restart(restart),
		.game_over(game_over), .game_tick(game_tick), .respawn(respawn),
		.obstacle_x(obstacle_x));

	score_keeper i_score (.Clock(Clock), .rst_n(rst_n), .restart(restart),
		.runner_y(runner_y), .ducking(ducking), .obstacle_x(obstacle_x),
		.game_over(game_over), .respawn(respawn), .score(score), .high_score(high_score));

	// Result
	score_display i_display (.score(score), .high_score(high_score),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5));

endmodule

/* sim/dino_tb.sv */
`timescale 1ns/1ps

module dino_tb;
	import dino_pkg::*;

	localparam int JUMP_LEAD = 34;		// Columns between obstacle and runner at key press
	localparam int OBSTACLES = 3;
	localparam int UART_BYTES = 12;
	localparam int BIT_CLKS = OS_DIV * BIT_OS;
	localparam int UART_CLKS = UART_BYTES * 11 * BIT_CLKS;	// Ten bits plus one idle bit each
	// Two extra obstacle runs for the crash tests
	localparam int TIMEOUT_CYCLES =
		2 * ((OBSTACLES + 2) * (int'(OBS_START) + OBS_RAND_MAX) * TICK_DIV + UART_CLKS);

	logic Clock = 1'b0;
	logic rst_n;
	logic uart_rx;
	logic jump_key;
	logic duck_key;
	logic restart;
	logic jump_cmd, duck_cmd, idle_cmd;
	logic game_over;
	logic [Y_W-1:0] runner_y;
	logic [X_W-1:0] obstacle_x;
	logic [SCORE_W-1:0] score, high_score;
	logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5;

	integer seed = 27662;
	int cycles = 0;
	int jump_seen = 0;
	int duck_seen = 0;
	int idle_seen = 0;

	dino_top i_dut (.Clock(Clock), .rst_n(rst_n), .uart_rx(uart_rx), .jump_key(jump_key),
		.duck_key(duck_key), .restart(restart), .jump_cmd(jump_cmd), .duck_cmd(duck_cmd),
		.idle_cmd(idle_cmd), .game_over(game_over), .runner_y(runner_y),
		.obstacle_x(obstacle_x), .score(score), .high_score(high_score),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5));

	always #20 Clock = ~Clock;

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the game never reached the expected state", cycles);
			$display("TEST FAILED");
			$fatal(1, "run limit reached");
		end
	end

	// Pulses are register outputs, stable at the falling edge
	always @(negedge Clock) begin
		if (rst_n) begin
			if (jump_cmd)
				jump_seen++;
			if (duck_cmd)
				duck_seen++;
			if (idle_cmd)
				idle_seen++;
		end
	end

	function automatic cmd_t expected_cmd(input logic [7:0] b);
		case (b)
			"J": return CMD_JUMP;
			"D": return CMD_DUCK;
			"I": return CMD_IDLE;
			default: return CMD_NONE;
		endcase
	endfunction

	// Height above ground with upward speed positive, one physics step per pass
	function automatic int jump_peak(output int steps);
		int h;
		int up;
		int peak;
		h = 0;
		up = -int'(JUMP_FORCE);
		peak = 0;
		steps = 0;
		do begin
			steps++;
			h = (h + up <= 0) ? 0 : h + up;		// Lands on the ground line
			up = up - int'(GRAVITY);
			if (h > peak)
				peak = h;
		end while (h > 0 && steps < 1000);
		return peak;
	endfunction

	// Segments a..g lit in bits 0..6, inverted for the active-low display
	function automatic logic [6:0] seg_pattern(input int digit);
		logic [6:0] lit;
		case (digit)
			0: lit = 7'b0111111;
			1: lit = 7'b0000110;
			2: lit = 7'b1011011;
			3: lit = 7'b1001111;
			4: lit = 7'b1100110;
			5: lit = 7'b1101101;
			6: lit = 7'b1111101;
			7: lit = 7'b0000111;
			8: lit = 7'b1111111;
			9: lit = 7'b1101111;
			default: lit = 7'b0000000;
		endcase
		return ~lit;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_display(input string name, input int s, input int h);
		check_value($sformatf("%s hex0", name), seg_pattern(s % 10), hex0);
		check_value($sformatf("%s hex1", name), seg_pattern((s / 10) % 10), hex1);
		check_value($sformatf("%s hex2", name), seg_pattern((s / 100) % 10), hex2);
		check_value($sformatf("%s hex3", name), seg_pattern(h % 10), hex3);
		check_value($sformatf("%s hex4", name), seg_pattern((h / 10) % 10), hex4);
		check_value($sformatf("%s hex5", name), seg_pattern((h / 100) % 10), hex5);
	endtask

	// 8N1, LSB first
	task automatic send_byte(input logic [7:0] data);
		int i;
		uart_rx = 1'b0;
		repeat (BIT_CLKS) @(negedge Clock);
		for (i = 0; i < 8; i++) begin
			uart_rx = data[i];
			repeat (BIT_CLKS) @(negedge Clock);
		end
		uart_rx = 1'b1;
		repeat (BIT_CLKS) @(negedge Clock);
	endtask

	task automatic press_jump();
		jump_key = 1'b1;
		repeat (4) @(negedge Clock);
		jump_key = 1'b0;
	endtask

	task automatic pulse_restart();
		restart = 1'b1;
		@(negedge Clock);
		restart = 1'b0;
	endtask

	initial begin
		logic [7:0] b;
		integer rnd;
		cmd_t c;
		int peak, steps, min_y, air_clks, frozen_x, k;
		int exp_jump, exp_duck, exp_idle;
		string seq;
		rst_n = 1'b0;
		uart_rx = 1'b1;
		jump_key = 1'b0;
		duck_key = 1'b0;
		restart = 1'b0;
		repeat (4) @(negedge Clock);
		rst_n = 1'b1;

		check_value("reset game_over", 0, game_over);
		check_value("reset score", 0, score);
		check_value("reset high_score", 0, high_score);
		check_value("reset runner_y", GROUND_Y, runner_y);
		check_value("reset obstacle_x", OBS_START, obstacle_x);
		check_display("reset", 0, 0);

		// Jump while the obstacle is still far away
		peak = jump_peak(steps);
		press_jump();
		while (runner_y == GROUND_Y)
			@(negedge Clock);
		min_y = runner_y;
		air_clks = 0;
		while (runner_y != GROUND_Y) begin
			if (runner_y < min_y)
				min_y = runner_y;
			@(negedge Clock);
			air_clks++;
		end
		check_value("jump peak", GROUND_Y - peak, min_y);
		check_value("jump airtime", (steps - 1) * PHYS_DIV * TICK_DIV, air_clks);
		repeat (2 * PHYS_DIV * TICK_DIV) @(negedge Clock);
		check_value("jump landing", GROUND_Y, runner_y);

		// No input, the runner must hit the first obstacle
		while (!game_over)
			@(negedge Clock);
		check_value("crash before pass", 1, obstacle_x > RUNNER_X);
		check_value("crash score", 0, score);
		frozen_x = obstacle_x;
		repeat (4 * TICK_DIV) @(negedge Clock);
		check_value("obstacle frozen", frozen_x, obstacle_x);
		check_value("crash high_score", 0, high_score);

		// Commands over UART while the game is frozen
		seq = "JDIIJD";
		exp_jump = jump_seen;
		exp_duck = duck_seen;
		exp_idle = idle_seen;
		for (k = 0; k < UART_BYTES; k++) begin
			if (k % 2 == 0) begin
				b = seq[k / 2];
			end else begin
				rnd = $random(seed);
				b = rnd[7:0];
			end
			c = expected_cmd(b);
			exp_jump += (c == CMD_JUMP);
			exp_duck += (c == CMD_DUCK);
			exp_idle += (c == CMD_IDLE);
			send_byte(b);
			repeat (BIT_CLKS) @(negedge Clock);
			check_value($sformatf("uart byte %0d jump count", k), exp_jump, jump_seen);
			check_value($sformatf("uart byte %0d duck count", k), exp_duck, duck_seen);
			check_value($sformatf("uart byte %0d idle count", k), exp_idle, idle_seen);
		end
		check_value("uart game_over held", 1, game_over);

		pulse_restart();
		check_value("restart game_over", 0, game_over);
		check_value("restart score", 0, score);
		check_value("restart obstacle_x", OBS_START, obstacle_x);
		for (k = 0; k < OBSTACLES; k++) begin
			while (obstacle_x != RUNNER_X + JUMP_LEAD && !game_over)
				@(negedge Clock);
			check_value($sformatf("obstacle %0d approach game_over", k), 0, game_over);
			press_jump();
			while (score == k && !game_over)
				@(negedge Clock);
			check_value($sformatf("obstacle %0d game_over", k), 0, game_over);
			check_value($sformatf("obstacle %0d score", k), k + 1, score);
			check_display($sformatf("obstacle %0d", k), k + 1, 0);
		end

		// Stop jumping and let the next obstacle end the round
		while (!game_over)
			@(negedge Clock);
		check_value("final score", OBSTACLES, score);
		for (k = 0; k < 4 && high_score != OBSTACLES; k++)
			@(negedge Clock);
		check_value("final high_score", OBSTACLES, high_score);
		check_display("final", OBSTACLES, OBSTACLES);
		pulse_restart();
		check_value("second restart game_over", 0, game_over);
		check_value("second restart score", 0, score);
		check_value("second restart high_score", OBSTACLES, high_score);
		check_display("second restart", 0, OBSTACLES);

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sim.f */
source/dino_pkg.sv
source/uart_receiver.sv
source/command_decoder.sv
source/runner_physics.sv
source/obstacle_track.sv
source/score_keeper.sv
source/score_display.sv
source/dino_top.sv
sim/dino_tb.sv
